/* Makefile */
# Verilator flow for the decode stage

VERILATOR ?= verilator
FILE_LIST ?= files.f
TOP       ?= decodeTb
RTL_TOP   ?= decodeStage
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

RTL_FILES := $(shell grep '^source/' $(FILE_LIST))
ALL_FILES := $(shell cat $(FILE_LIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

$(BUILD_DIR)/$(TOP): $(ALL_FILES) $(FILE_LIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
source/isaPkg.sv
source/decodePkg.sv
source/decodeAlu.sv
source/decodeMem.sv
source/decodeRegs.sv
source/stageReg.sv
source/decodeStage.sv
verification/decodeAssertions.sv
verification/decodeTb.sv

/* source/decodeAlu.sv */
`default_nettype none

module decodeAlu
(
	input  wire isaPkg::instruction_t instr,
	output logic                      alu
);

	import isaPkg::*;

	// ==========================================================================
	// ALU classification
	// ==========================================================================

	// Loads and stores count as ALU work because the address add runs there
	// Prefix and NOP words also occupy an ALU slot so they retire in order
	always_comb
	begin
		case (instr.r2.opcode)
			// System operations go to their own unit
			OP_SYS:
				alu = 1'b0;
			// Register form is ALU only for a defined function code
			OP_R2:
			begin
				case (instr.r2.func)
					FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU:
						alu = 1'b1;
					FN_AND, FN_OR, FN_EOR, FN_ANDC:
						alu = 1'b1;
					FN_NAND, FN_NOR, FN_ENOR, FN_ORC:
						alu = 1'b1;
					FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						alu = 1'b1;
					// Unknown function is treated like an unknown opcode
					default:
						alu = 1'b0;
				endcase
			end
			// Immediate arithmetic
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI:
				alu = 1'b1;
			// Immediate logic and compare
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI:
				alu = 1'b1;
			// Shifts, CSR access and register move
			OP_SHIFT, OP_CSR, OP_MOV:
				alu = 1'b1;
			// Loads, including the address-only LDA
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA:
				alu = 1'b1;
			// Indexed load needs Ra plus Rb
			OP_LDX:
				alu = 1'b1;
			// Stores
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STX:
				alu = 1'b1;
			// Prefix and NOP are classified only
			OP_PFX, OP_NOP:
				alu = 1'b1;
			// Any undefined opcode
			default:
				alu = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/decodeMem.sv */
`default_nettype none

module decodeMem
(
	input  wire isaPkg::instruction_t instr,
	output logic                      load,
	output logic                      store,
	output decodePkg::memSize_t       memSize,
	output logic                      unsignedLoad,
	output logic                      indexed
);

	import isaPkg::*;
	import decodePkg::*;

	// ==========================================================================
	// Load and store classification
	// ==========================================================================

	// Defaults describe a non-memory instruction
	// Size rests at octa so that idle bits do not toggle on ALU words
	always_comb
	begin
		load         = 1'b0;
		store        = 1'b0;
		memSize      = SZ_OCTA;
		unsignedLoad = 1'b0;
		indexed      = 1'b0;
		case (instr.r2.opcode)
			// Signed and unsigned byte
			OP_LDB, OP_LDBU:
			begin
				load         = 1'b1;
				memSize      = SZ_BYTE;
				unsignedLoad = (instr.r2.opcode == OP_LDBU);
			end
			// Signed and unsigned wyde
			OP_LDW, OP_LDWU:
			begin
				load         = 1'b1;
				memSize      = SZ_WYDE;
				unsignedLoad = (instr.r2.opcode == OP_LDWU);
			end
			// Signed and unsigned tetra
			OP_LDT, OP_LDTU:
			begin
				load         = 1'b1;
				memSize      = SZ_TETRA;
				unsignedLoad = (instr.r2.opcode == OP_LDTU);
			end
			// Octa fills the register, so there is no U form
			OP_LDO:
				load = 1'b1;
			// Indexed forms carry the size in the low two func bits
			OP_LDX:
			begin
				load    = 1'b1;
				indexed = 1'b1;
				memSize = memSize_t'(instr.r2.func[1:0]);
			end
			OP_STB:
			begin
				store   = 1'b1;
				memSize = SZ_BYTE;
			end
			OP_STW:
			begin
				store   = 1'b1;
				memSize = SZ_WYDE;
			end
			OP_STT:
			begin
				store   = 1'b1;
				memSize = SZ_TETRA;
			end
			OP_STO:
				store = 1'b1;
			OP_STX:
			begin
				store   = 1'b1;
				indexed = 1'b1;
				memSize = memSize_t'(instr.r2.func[1:0]);
			end
			// LDA only forms an address, it never touches memory
			default:
				load = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/decodePkg.sv */
`default_nettype none

package decodePkg;

	// ==========================================================================
	// Memory access size
	// ==========================================================================

	// Byte, wyde (16), tetra (32) and octa (64)
	typedef enum logic [1:0]
	{
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memSize_t;

	// ==========================================================================
	// Stage payloads
	// ==========================================================================

	// Everything the issue stage needs to know about one instruction
	typedef struct packed
	{
		logic             alu;
		logic             load;
		logic             store;
		memSize_t         memSize;
		logic             unsignedLoad;
		logic             indexed;
		logic             hasImm;
		logic             rbValid;
		logic             writesRt;
		isaPkg::regNum_t  rt;
		isaPkg::regNum_t  ra;
		isaPkg::regNum_t  rb;
		logic [20:0]      imm;
	} decodeBus_t;

	// Contents of the instruction register
	typedef struct packed
	{
		isaPkg::instruction_t instr;
	} fetchWord_t;

endpackage

`default_nettype wire

/* source/decodeRegs.sv */
`default_nettype none

module decodeRegs
(
	input  wire isaPkg::instruction_t instr,
	output isaPkg::regNum_t           rt,
	output isaPkg::regNum_t           ra,
	output isaPkg::regNum_t           rb,
	output logic [20:0]               imm,
	output logic                      hasImm,
	output logic                      rbValid,
	output logic                      writesRt
);

	import isaPkg::*;

	// ==========================================================================
	// Register fields
	// ==========================================================================

	// Register numbers sit at the same place in every format
	assign rt = instr.r2.rt;
	assign ra = instr.r2.ra;
	assign rb = instr.r2.rb;

	// Immediate is forced to zero when the word has none
	assign imm = hasImm ? instr.ri.imm : 21'd0;

	// ==========================================================================
	// Operand use and writeback
	// ==========================================================================

	// Stores, PFX and NOP never write Rt, so only the rest of the ALU set
	// needs to be recognised here
	always_comb
	begin
		hasImm   = 1'b0;
		rbValid  = 1'b0;
		writesRt = 1'b0;
		case (instr.r2.opcode)
			OP_R2:
			begin
				rbValid = 1'b1;
				case (instr.r2.func)
					FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB, FN_MULU, FN_DIVU,
					FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR, FN_ENOR,
					FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
						writesRt = 1'b1;
					default:
						writesRt = 1'b0;
				endcase
			end
			OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI,
			OP_ANDI, OP_ORI, OP_EORI, OP_SLTI, OP_CSR:
			begin
				hasImm   = 1'b1;
				writesRt = 1'b1;
			end
			// Shift amount comes from Rb
			OP_SHIFT:
			begin
				rbValid  = 1'b1;
				writesRt = 1'b1;
			end
			OP_MOV:
				writesRt = 1'b1;
			// Displacement loads and LDA
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDA:
			begin
				hasImm   = 1'b1;
				writesRt = 1'b1;
			end
			OP_LDX:
			begin
				rbValid  = 1'b1;
				writesRt = 1'b1;
			end
			// Rt is the data source of a store
			OP_STB, OP_STW, OP_STT, OP_STO:
				hasImm = 1'b1;
			OP_STX:
				rbValid = 1'b1;
			default:
				hasImm = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/decodeStage.sv */
`default_nettype none

module decodeStage
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire isaPkg::instruction_t instrIn,
	input  wire logic                 instrValid,
	input  wire logic                 stall,
	output decodePkg::decodeBus_t     decodeOut,
	output logic                      decodeValid
);

	import decodePkg::*;

	// Instruction register contents
	wire fetchWord_t fetchQ;
	wire             fetchValid;

	// Combined result of the three decoders, before the output register
	wire decodeBus_t nextBus;

	// ==========================================================================
	// Instruction register
	// ==========================================================================

	// A word enters on an edge with instrValid high and stall low
	stageReg #(.payload_t(fetchWord_t)) u_fetchReg
	(
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.inValid  (instrValid),
		.inData   (fetchWord_t'(instrIn)),
		.outValid (fetchValid),
		.outData  (fetchQ)
	);

	// ==========================================================================
	// Decoders
	// ==========================================================================

	// All three look at the same registered word in parallel
	decodeAlu u_decodeAlu
	(
		.instr (fetchQ.instr),
		.alu   (nextBus.alu)
	);

	decodeMem u_decodeMem
	(
		.instr        (fetchQ.instr),
		.load         (nextBus.load),
		.store        (nextBus.store),
		.memSize      (nextBus.memSize),
		.unsignedLoad (nextBus.unsignedLoad),
		.indexed      (nextBus.indexed)
	);

	decodeRegs u_decodeRegs
	(
		.instr    (fetchQ.instr),
		.rt       (nextBus.rt),
		.ra       (nextBus.ra),
		.rb       (nextBus.rb),
		.imm      (nextBus.imm),
		.hasImm   (nextBus.hasImm),
		.rbValid  (nextBus.rbValid),
		.writesRt (nextBus.writesRt)
	);

	// ==========================================================================
	// Output register
	// ==========================================================================

	// Decode appears one edge after the word was captured
	stageReg #(.payload_t(decodeBus_t)) u_decodeReg
	(
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.inValid  (fetchValid),
		.inData   (nextBus),
		.outValid (decodeValid),
		.outData  (decodeOut)
	);

endmodule

`default_nettype wire

/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

	// ==========================================================================
	// Major opcodes
	// ==========================================================================

	// Codes missing from this list are undefined and never execute on the ALU
	typedef enum logic [6:0]
	{
		OP_SYS    = 7'd0,
		OP_R2     = 7'd2,
		OP_ADDI   = 7'd4,
		OP_SUBFI  = 7'd5,
		OP_CMPI   = 7'd6,
		OP_MULI   = 7'd7,
		OP_DIVI   = 7'd8,
		OP_ANDI   = 7'd9,
		OP_ORI    = 7'd10,
		OP_EORI   = 7'd11,
		OP_SLTI   = 7'd12,
		OP_SHIFT  = 7'd13,
		OP_CSR    = 7'd14,
		OP_MOV    = 7'd15,
		// Loads sit in one block, the U forms directly after the signed ones
		OP_LDB    = 7'd64,
		OP_LDBU   = 7'd65,
		OP_LDW    = 7'd66,
		OP_LDWU   = 7'd67,
		OP_LDT    = 7'd68,
		OP_LDTU   = 7'd69,
		OP_LDO    = 7'd70,
		OP_LDA    = 7'd74,
		OP_LDX    = 7'd79,
		// Stores follow the loads
		OP_STB    = 7'd80,
		OP_STW    = 7'd81,
		OP_STT    = 7'd82,
		OP_STO    = 7'd83,
		OP_STX    = 7'd87,
		OP_PFX    = 7'd124,
		OP_NOP    = 7'd127
	} opcode_t;

	// ==========================================================================
	// R2 function codes
	// ==========================================================================

	// Arithmetic in the low group, logic at 16 and set operations at 32
	typedef enum logic [6:0]
	{
		FN_ADD  = 7'd4,
		FN_CMP  = 7'd5,
		FN_MUL  = 7'd6,
		FN_DIV  = 7'd7,
		FN_SUB  = 7'd8,
		FN_MULU = 7'd9,
		FN_DIVU = 7'd10,
		FN_AND  = 7'd16,
		FN_OR   = 7'd17,
		FN_EOR  = 7'd18,
		FN_ANDC = 7'd19,
		FN_NAND = 7'd20,
		FN_NOR  = 7'd21,
		FN_ENOR = 7'd22,
		FN_ORC  = 7'd23,
		FN_SEQ  = 7'd32,
		FN_SNE  = 7'd33,
		FN_SLT  = 7'd34,
		FN_SLE  = 7'd35,
		FN_SLTU = 7'd36,
		FN_SLEU = 7'd37
	} func_t;

	// ==========================================================================
	// Instruction formats
	// ==========================================================================

	typedef logic [5:0] regNum_t;

	// Register form, fields listed from the top bit down
	typedef struct packed
	{
		func_t      func;
		logic [1:0] spare;
		regNum_t    rc;
		regNum_t    rb;
		regNum_t    ra;
		regNum_t    rt;
		opcode_t    opcode;
	} r2Format_t;

	// Immediate form shares opcode, Rt and Ra positions with the register form
	typedef struct packed
	{
		logic [20:0] imm;
		regNum_t     ra;
		regNum_t     rt;
		opcode_t     opcode;
	} immFormat_t;

	typedef union packed
	{
		r2Format_t  r2;
		immFormat_t ri;
	} instruction_t;

endpackage

`default_nettype wire

/* source/stageReg.sv */
`default_nettype none

module stageReg
#(
	parameter type payload_t = logic [39:0]
)
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     stall,
	input  wire logic     inValid,
	input  wire payload_t inData,
	output logic          outValid,
	output payload_t      outData
);

	// ==========================================================================
	// Pipeline register
	// ==========================================================================

	// Stall freezes valid and payload together so that a held slot
	// still shows the same word when the stall lifts
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			outData  <= '0;
		end
		else if (!stall)
		begin
			// Payload follows even for an empty slot, valid marks it
			outValid <= inValid;
			outData  <= inData;
		end
	end

endmodule

`default_nettype wire

/* verification/decodeAssertions.sv */
`default_nettype none

module decodeAssertions
(
	input wire logic                  clk,
	input wire logic                  rst,
	input wire logic                  stall,
	input wire decodePkg::decodeBus_t decodeOut,
	input wire logic                  decodeValid
);

	// ==========================================================================
	// Reset behavior
	// ==========================================================================

	// Every reset edge empties the output slot
	validLowAfterResetEdge: assert property (@(posedge clk) rst |=> !decodeValid)
		else $error("decodeValid was high after a reset edge");

	// The first edge out of reset loads the still empty instruction register slot
	validLowAfterRelease: assert property (@(posedge clk) $fell(rst) |=> !decodeValid)
		else $error("decodeValid rose on the cycle after reset");

	// ==========================================================================
	// Stall and decode consistency
	// ==========================================================================

	// A stalled edge must leave the output register untouched
	stallHoldsOutput: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(decodeOut) && $stable(decodeValid))
		else $error("decode output changed across a stalled edge");

	// An instruction is either a load or a store, never both
	loadStoreExclusive: assert property (@(posedge clk) disable iff (rst)
		!(decodeOut.load && decodeOut.store))
		else $error("load and store were both high");

	// Anything the ALU does not take can neither access memory nor write Rt
	nonAluIsQuiet: assert property (@(posedge clk) disable iff (rst)
		!decodeOut.alu |-> !decodeOut.load && !decodeOut.store && !decodeOut.writesRt)
		else $error("a non-ALU instruction raised load, store or writesRt");

endmodule

`default_nettype wire

/* verification/decodeTb.sv */
`default_nettype none

module decodeTb;

	import isaPkg::*;
	import decodePkg::*;

	// Test lengths, and the watchdog budget of four cycles per word
	localparam int unsigned seedValue        = 60982;
	localparam int          memRepeats       = 16;
	localparam int          randomStallWords = 1000;
	localparam int          regFieldWords    = 2000;
	localparam int          numTests         = 1 + 128 + 128 + 14 * memRepeats
		+ randomStallWords + regFieldWords;
	localparam int          watchdogLimit    = (numTests + 50) * 8 * 4;

	logic         clk;
	logic         rst;
	instruction_t instrIn;
	logic         instrValid;
	logic         stall;
	decodeBus_t   decodeOut;
	logic         decodeValid;

	// Words the DUT accepted, oldest first
	instruction_t acceptedQ [$];
	decodeBus_t   lastBus;
	logic         lastValid;

	// Every load, store and address form
	opcode_t memOps [0:13] = '{OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
		OP_LDO, OP_LDA, OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};

	decodeStage u_dut
	(
		.clk         (clk),
		.rst         (rst),
		.instrIn     (instrIn),
		.instrValid  (instrValid),
		.stall       (stall),
		.decodeOut   (decodeOut),
		.decodeValid (decodeValid)
	);

	bind decodeStage decodeAssertions u_assertions
	(
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.decodeOut   (decodeOut),
		.decodeValid (decodeValid)
	);

	always #4 clk = ~clk;

	// ==========================================================================
	// Reference decode
	// ==========================================================================

	// Fields are cut straight from the bit layout of the formats
	function automatic decodeBus_t refDecode(input instruction_t instr);
		logic [39:0] bits;
		logic [6:0]  fn;
		opcode_t     op;
		logic        isLoad;
		logic        isStore;
		logic        immAlu;
		logic        r2Alu;
		decodeBus_t  bus;
		bits    = instr;
		op      = opcode_t'(bits[6:0]);
		fn      = bits[39:33];
		isLoad  = op inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO,
			OP_LDX};
		isStore = op inside {OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
		immAlu  = op inside {OP_ADDI, OP_SUBFI, OP_CMPI, OP_MULI, OP_DIVI, OP_ANDI,
			OP_ORI, OP_EORI, OP_SLTI};
		r2Alu   = (op == OP_R2) && (fn inside {FN_ADD, FN_CMP, FN_MUL, FN_DIV, FN_SUB,
			FN_MULU, FN_DIVU, FN_AND, FN_OR, FN_EOR, FN_ANDC, FN_NAND, FN_NOR, FN_ENOR,
			FN_ORC, FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU});
		bus     = '0;
		// Address generation puts every memory form on the ALU
		bus.alu = r2Alu || immAlu || isLoad || isStore
			|| (op inside {OP_SHIFT, OP_CSR, OP_MOV, OP_LDA, OP_PFX, OP_NOP});
		bus.load         = isLoad;
		bus.store        = isStore;
		bus.indexed      = (op == OP_LDX) || (op == OP_STX);
		bus.unsignedLoad = op inside {OP_LDBU, OP_LDWU, OP_LDTU};
		case (op)
			OP_LDB, OP_LDBU, OP_STB:
				bus.memSize = SZ_BYTE;
			OP_LDW, OP_LDWU, OP_STW:
				bus.memSize = SZ_WYDE;
			OP_LDT, OP_LDTU, OP_STT:
				bus.memSize = SZ_TETRA;
			// Indexed forms take the size from the bottom of func
			OP_LDX, OP_STX:
				bus.memSize = memSize_t'(fn[1:0]);
			default:
				bus.memSize = SZ_OCTA;
		endcase
		bus.hasImm   = immAlu || (op == OP_CSR)
			|| ((isLoad || isStore || (op == OP_LDA)) && !bus.indexed);
		bus.rbValid  = op inside {OP_R2, OP_SHIFT, OP_LDX, OP_STX};
		bus.writesRt = bus.alu && !isStore && (op != OP_PFX) && (op != OP_NOP);
		bus.rt       = bits[12:7];
		bus.ra       = bits[18:13];
		bus.rb       = bits[24:19];
		bus.imm      = bus.hasImm ? bits[39:19] : 21'd0;
		return bus;
	endfunction

	// ==========================================================================
	// Checks
	// ==========================================================================

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic compareField(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input string where);
		if (expected !== actual)
			failRun($sformatf("ERROR: %s expected 0x%0h got 0x%0h (%s)", name, expected,
				actual, where));
	endtask

	task automatic checkBus(input decodeBus_t expected, input decodeBus_t actual,
		input string where);
		compareField("decodeOut.alu", 32'(expected.alu), 32'(actual.alu), where);
		compareField("decodeOut.load", 32'(expected.load), 32'(actual.load), where);
		compareField("decodeOut.store", 32'(expected.store), 32'(actual.store), where);
		compareField("decodeOut.memSize", 32'(expected.memSize), 32'(actual.memSize), where);
		compareField("decodeOut.unsignedLoad", 32'(expected.unsignedLoad),
			32'(actual.unsignedLoad), where);
		compareField("decodeOut.indexed", 32'(expected.indexed), 32'(actual.indexed), where);
		compareField("decodeOut.hasImm", 32'(expected.hasImm), 32'(actual.hasImm), where);
		compareField("decodeOut.rbValid", 32'(expected.rbValid), 32'(actual.rbValid), where);
		compareField("decodeOut.writesRt", 32'(expected.writesRt), 32'(actual.writesRt),
			where);
		compareField("decodeOut.rt", 32'(expected.rt), 32'(actual.rt), where);
		compareField("decodeOut.ra", 32'(expected.ra), 32'(actual.ra), where);
		compareField("decodeOut.rb", 32'(expected.rb), 32'(actual.rb), where);
		compareField("decodeOut.imm", 32'(expected.imm), 32'(actual.imm), where);
	endtask

	task automatic checkValid(input logic expected, input logic actual, input string where);
		compareField("decodeValid", 32'(expected), 32'(actual), where);
	endtask

	// ==========================================================================
	// Stimulus
	// ==========================================================================

	function automatic instruction_t randomWord();
		logic [63:0] raw;
		raw = {$urandom(), $urandom()};
		return instruction_t'(raw[39:0]);
	endfunction

	// Walks the enumeration so only listed opcodes come out
	function automatic opcode_t randomDefinedOpcode();
		opcode_t     op;
		int unsigned steps;
		op    = op.first();
		steps = $urandom_range(op.num() - 1);
		repeat (steps)
			op = op.next();
		return op;
	endfunction

	// The word stays on the bus until an edge without stall takes it
	task automatic sendWord(input instruction_t word, input int unsigned stallPercent);
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
		begin
			instrIn    = word;
			instrValid = 1'b1;
			stall      = ($urandom_range(99) < stallPercent);
			@(posedge clk);
			accepted = !stall;
			#1;
		end
		instrValid = 1'b0;
		stall      = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		instrValid = 1'b0;
		stall      = 1'b0;
		repeat (count)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// Output stays empty until the first word, then fills two edges later
	task automatic checkResetLatency();
		instruction_t word;
		repeat (3)
		begin
			@(posedge clk);
			#1;
			checkValid(1'b0, decodeValid, "idle after reset");
		end
		word           = randomWord();
		word.r2.opcode = OP_ADDI;
		instrIn        = word;
		instrValid     = 1'b1;
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		checkValid(1'b0, decodeValid, "one edge after acceptance");
		@(posedge clk);
		#1;
		checkValid(1'b1, decodeValid, "two edges after acceptance");
	endtask

	task automatic sendAllOpcodes();
		instruction_t word;
		for (int code = 0; code < 128; code++)
		begin
			word           = randomWord();
			word.r2.opcode = opcode_t'(7'(code));
			sendWord(word, 0);
		end
	endtask

	task automatic sendAllFunctions();
		instruction_t word;
		for (int code = 0; code < 128; code++)
		begin
			word           = randomWord();
			word.r2.opcode = OP_R2;
			word.r2.func   = func_t'(7'(code));
			sendWord(word, 0);
		end
	endtask

	task automatic sendMemoryForms();
		instruction_t word;
		foreach (memOps[i])
		begin
			repeat (memRepeats)
			begin
				word           = randomWord();
				word.r2.opcode = memOps[i]; 
				sendWord(word, 0);
			end
		end
	endtask

	// Three words in four carry a defined opcode, the rest are raw bits
	task automatic sendRandomWords(input int count, input int unsigned stallPercent);
		instruction_t word;
		repeat (count)
		begin
			word = randomWord();
			if ($urandom_range(3) != 0)
				word.r2.opcode = randomDefinedOpcode();
			sendWord(word, stallPercent);
		end
	endtask

	// ==========================================================================
	// Scoreboard
	// ==========================================================================

	// Inputs and stall are sampled at the edge, outputs two units later
	initial
	begin : scoreboard
		logic       wasReset;
		logic       wasStall;
		decodeBus_t expected;
		lastBus   = '0;
		lastValid = 1'b0;
		forever
		begin
			@(posedge clk);
			wasReset = rst;
			wasStall = stall;
			if (!rst && instrValid && !stall)
				acceptedQ.push_back(instrIn);
			#2;
			if (wasReset)
			begin
				// Reset empties the slot and clears its payload
				checkValid(1'b0, decodeValid, "during reset");
				checkBus('0, decodeOut, "during reset");
			end
			else if (wasStall)
			begin
				checkBus(lastBus, decodeOut, "held under stall");
				checkValid(lastValid, decodeValid, "held under stall");
			end
			else if (decodeValid)
			begin
				if (acceptedQ.size() == 0)
					failRun("The decode stage produced a result for a word it never accepted");
				else
				begin
					expected = refDecode(acceptedQ.pop_front());
					checkBus(expected, decodeOut, "decode result");
				end
			end
			lastBus   = decodeOut;
			lastValid = decodeValid;
		end
	end

	initial
	begin : watchdog
		#(watchdogLimit);
		failRun("Timeout: the decode stage stopped producing results");
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial
	begin
		void'($urandom(seedValue));
		clk        = 1'b0;
		rst        = 1'b1;
		instrIn    = '0;
		instrValid = 1'b0;
		stall      = 1'b0;
		repeat (16)
			@(posedge clk);
		#1;
		rst = 1'b0;
		checkResetLatency();
		sendAllOpcodes();
		sendAllFunctions();
		sendMemoryForms();
		sendRandomWords(randomStallWords, 25);
		sendRandomWords(regFieldWords, 0);
		// Two idle edges flush both registers
		idleCycles(8);
		checkValid(1'b0, decodeValid, "after drain");
		if (acceptedQ.size() != 0)
			failRun("Accepted words never came out of the decode stage");
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
